//--- verilog/pipeline_defines.svh
`ifndef PIPELINE_DEFINES_SVH
`define PIPELINE_DEFINES_SVH

//////////////////////////////
// Datapath sizes
//////////////////////////////

// Register and ALU width
`define DATA_WIDTH 32

// Architectural register count
`define REG_COUNT 32

// Bits to address one register
`define REG_ADDR_WIDTH 5

//////////////////////////////
// ALUSrc1 selector values
//////////////////////////////

// Operand B from the rt register
`define SRC1_RT 2'd0
// Operand B from the extended immediate
`define SRC1_IMM 2'd1
// Operand B is the immediate in the upper half, lui only
`define SRC1_UPPER 2'd2

`endif

//--- verilog/pipelinePkg.sv
package pipelinePkg;

  //////////////////////////////
  // Instruction word layouts
  //////////////////////////////

  // R-type field layout
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFields;

  // I-type field layout
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFields;

  // Same 32 bits, read either way
  typedef union packed {
    rFields rFmt;
    iFields iFmt;
  } instrWord;

  //////////////////////////////
  // Opcodes and functs
  //////////////////////////////

  // SPECIAL selects the funct table
  typedef enum logic [5:0] {
    SPECIAL = 6'h00,
    ADDI    = 6'h08,
    ADDIU   = 6'h09,
    SLTI    = 6'h0a,
    SLTIU   = 6'h0b,
    ANDI    = 6'h0c,
    ORI     = 6'h0d,
    XORI    = 6'h0e,
    LUI     = 6'h0f,
    LB      = 6'h20,
    LH      = 6'h21,
    LW      = 6'h23,
    SB      = 6'h28,
    SH      = 6'h29,
    SW      = 6'h2b
  } opcodeType;

  typedef enum logic [5:0] {
    F_SLL  = 6'h00,
    F_SRL  = 6'h02,
    F_SRA  = 6'h03,
    F_ADD  = 6'h20,
    F_ADDU = 6'h21,
    F_SUB  = 6'h22,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_NOR  = 6'h27,
    F_SLT  = 6'h2a,
    F_SLTU = 6'h2b
  } functType;

  // ALU operations, ADD doubles as the bubble value
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS
  } aluOpType;

endpackage

//--- verilog/instructionDecoder.sv
`include "pipeline_defines.svh"

module instructionDecoder (
  input  pipelinePkg::instrWord  instr,
  input  logic                   instrValid,
  output logic [`REG_ADDR_WIDTH-1:0] rs,
  output logic [`REG_ADDR_WIDTH-1:0] rt,
  output logic [`REG_ADDR_WIDTH-1:0] rd,
  output logic [4:0]             shamt,
  output pipelinePkg::aluOpType  aluOp,
  output logic                   regDst,
  output logic                   aluSrc0,
  output logic [1:0]             aluSrc1,
  output logic [`DATA_WIDTH-1:0] imm32,
  output logic                   regWrite,
  output logic                   memToReg,
  output logic                   memRead,
  output logic                   memWrite,
  output logic [1:0]             memWidth,
  output logic                   valid
);
  import pipelinePkg::*;

  opcodeType opcode;
  functType  funct;
  logic      signExt;
  logic      supported;

  // Opcode sits in the same bits for both layouts
  assign opcode = opcodeType'(instr.iFmt.opcode);
  assign funct  = functType'(instr.rFmt.funct);

  // Register fields, rd and shamt only mean something for R-type
  assign rs    = instr.iFmt.rs;
  assign rt    = instr.iFmt.rt;
  assign rd    = instr.rFmt.rd;
  assign shamt = instr.rFmt.shamt;

  // Logical immediates zero-extend, everything else sign-extends
  assign imm32 = signExt ? {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm}
                         : {16'b0, instr.iFmt.imm};

  always_comb begin
    aluOp     = ALU_ADD;
    regDst    = 1'b0;
    aluSrc0   = 1'b0;
    aluSrc1   = `SRC1_IMM;
    signExt   = 1'b1;
    regWrite  = 1'b0;
    memToReg  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    memWidth  = 2'd0;
    supported = 1'b1;
    case (opcode)
      SPECIAL: begin
        regDst   = 1'b1;
        aluSrc1  = `SRC1_RT;
        regWrite = 1'b1;
        // Overflow traps not modelled, add acts as addu
        case (funct)
          F_ADD, F_ADDU: aluOp = ALU_ADD;
          F_SUB, F_SUBU: aluOp = ALU_SUB;
          F_AND:  aluOp = ALU_AND;
          F_OR:   aluOp = ALU_OR;
          F_XOR:  aluOp = ALU_XOR;
          F_NOR:  aluOp = ALU_NOR;
          F_SLT:  aluOp = ALU_SLT;
          F_SLTU: aluOp = ALU_SLTU;
          F_SLL, F_SRL, F_SRA: begin
            // Shift amount from the shamt field
            aluSrc0 = 1'b1;
            aluOp   = (funct == F_SLL) ? ALU_SLL :
                      (funct == F_SRL) ? ALU_SRL : ALU_SRA;
          end
          default: supported = 1'b0;
        endcase
      end
      ADDI, ADDIU: regWrite = 1'b1;
      SLTI, SLTIU: begin
        aluOp    = (opcode == SLTI) ? ALU_SLT : ALU_SLTU;
        regWrite = 1'b1;
      end
      ANDI, ORI, XORI: begin
        signExt  = 1'b0;
        regWrite = 1'b1;
        aluOp    = (opcode == ANDI) ? ALU_AND :
                   (opcode == ORI)  ? ALU_OR  : ALU_XOR;
      end
      LUI: begin
        aluOp    = ALU_PASS;
        aluSrc1  = `SRC1_UPPER;
        regWrite = 1'b1;
      end
      // No data memory behind the loads, so they never write back
      LB, LH, LW: begin
        memRead  = 1'b1;
        memToReg = 1'b1;
        memWidth = (opcode == LB) ? 2'd0 : (opcode == LH) ? 2'd1 : 2'd2;
      end
      SB, SH, SW: begin
        memWrite = 1'b1;
        memWidth = (opcode == SB) ? 2'd0 : (opcode == SH) ? 2'd1 : 2'd2;
      end
      default: supported = 1'b0;
    endcase
    // Unknown codes and empty slots turn into no-ops
    if (!(instrValid && supported)) begin
      regWrite = 1'b0;
      memToReg = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
    end
  end

  assign valid = instrValid && supported;

endmodule

//--- verilog/registerFile.sv
`include "pipeline_defines.svh"

module registerFile (
  input  logic                       Clock,
  input  logic                       rst,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
  input  logic                       writeEnable,
  input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  input  logic [`DATA_WIDTH-1:0]     writeData,
  output logic [`DATA_WIDTH-1:0]     readData1,
  output logic [`DATA_WIDTH-1:0]     readData2
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
  logic                   writeLive;

  // Register zero is hardwired, writes to it are dropped
  assign writeLive = writeEnable && (writeAddr != '0);

  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Write-through so the slot two behind a writer sees the new value
  assign readData1 = (writeLive && writeAddr == readAddr1) ? writeData : regs[readAddr1];
  assign readData2 = (writeLive && writeAddr == readAddr2) ? writeData : regs[readAddr2];

  // r0 reads as zero on both ports, bypass path included
  assert property (@(posedge Clock) disable iff (rst)
                   (readAddr1 == '0) |-> (readData1 == '0))
    else $error("Register zero read back nonzero on port 1");
  assert property (@(posedge Clock) disable iff (rst)
                   (readAddr2 == '0) |-> (readData2 == '0))
    else $error("Register zero read back nonzero on port 2");

endmodule

//--- verilog/decodeToExecute.sv
`include "pipeline_defines.svh"

module decodeToExecute (
  input  logic                       Clock,
  input  logic                       rst,
  input  logic                       stall,
  // Write-back controls
  input  logic                       validIn,
  input  logic                       regWriteIn,
  input  logic                       memToRegIn,
  // Memory controls
  input  logic                       memReadIn,
  input  logic                       memWriteIn,
  input  logic [1:0]                 memWidthIn,
  // Execute controls
  input  pipelinePkg::aluOpType      aluOpIn,
  input  logic                       regDstIn,
  input  logic                       aluSrc0In,
  input  logic [1:0]                 aluSrc1In,
  // Execute data
  input  logic [4:0]                 shamtIn,
  input  logic [`DATA_WIDTH-1:0]     regData1In,
  input  logic [`DATA_WIDTH-1:0]     regData2In,
  input  logic [`DATA_WIDTH-1:0]     imm32In,
  input  logic [`REG_ADDR_WIDTH-1:0] rtIn,
  input  logic [`REG_ADDR_WIDTH-1:0] rdIn,
  output logic                       validOut,
  output logic                       regWriteOut,
  output logic                       memToRegOut,
  output logic                       memReadOut,
  output logic                       memWriteOut,
  output logic [1:0]                 memWidthOut,
  output pipelinePkg::aluOpType      aluOpOut,
  output logic                       regDstOut,
  output logic                       aluSrc0Out,
  output logic [1:0]                 aluSrc1Out,
  output logic [4:0]                 shamtOut,
  output logic [`DATA_WIDTH-1:0]     regData1Out,
  output logic [`DATA_WIDTH-1:0]     regData2Out,
  output logic [`DATA_WIDTH-1:0]     imm32Out,
  output logic [`REG_ADDR_WIDTH-1:0] rtOut,
  output logic [`REG_ADDR_WIDTH-1:0] rdOut
);
  import pipelinePkg::*;

  always_ff @(posedge Clock) begin
    if (rst || stall) begin
      // Bubble, every field cleared
      validOut    <= 1'b0;
      regWriteOut <= 1'b0;
      memToRegOut <= 1'b0;
      memReadOut  <= 1'b0;
      memWriteOut <= 1'b0;
      memWidthOut <= 2'd0;
      aluOpOut    <= ALU_ADD;
      regDstOut   <= 1'b0;
      aluSrc0Out  <= 1'b0;
      aluSrc1Out  <= 2'd0;
      shamtOut    <= '0;
      regData1Out <= '0;
      regData2Out <= '0;
      imm32Out    <= '0;
      rtOut       <= '0;
      rdOut       <= '0;
    end else begin
      validOut    <= validIn;
      regWriteOut <= regWriteIn;
      memToRegOut <= memToRegIn;
      memReadOut  <= memReadIn;
      memWriteOut <= memWriteIn;
      memWidthOut <= memWidthIn;
      aluOpOut    <= aluOpIn;
      regDstOut   <= regDstIn;
      aluSrc0Out  <= aluSrc0In;
      aluSrc1Out  <= aluSrc1In;
      shamtOut    <= shamtIn;
      regData1Out <= regData1In;
      regData2Out <= regData2In;
      imm32Out    <= imm32In;
      rtOut       <= rtIn;
      rdOut       <= rdIn;
    end
  end

  // An empty slot, bubble included, carries no side effects into execute
  assert property (@(posedge Clock) disable iff (rst)
                   !validOut |-> (!regWriteOut && !memReadOut && !memWriteOut))
    else $error("Empty slot left a write or memory request active");

endmodule

//--- verilog/executeUnit.sv
`include "pipeline_defines.svh"

module executeUnit (
  input  logic                       Clock,
  input  logic                       rst,
  input  logic                       validOut,
  input  logic                       regWriteOut,
  input  logic                       memToRegOut,
  input  logic                       memReadOut,
  input  logic                       memWriteOut,
  input  logic [1:0]                 memWidthOut,
  input  pipelinePkg::aluOpType      aluOpOut,
  input  logic                       regDstOut,
  input  logic                       aluSrc0Out,
  input  logic [1:0]                 aluSrc1Out,
  input  logic [4:0]                 shamtOut,
  input  logic [`DATA_WIDTH-1:0]     regData1Out,
  input  logic [`DATA_WIDTH-1:0]     regData2Out,
  input  logic [`DATA_WIDTH-1:0]     imm32Out,
  input  logic [`REG_ADDR_WIDTH-1:0] rtOut,
  input  logic [`REG_ADDR_WIDTH-1:0] rdOut,
  output logic                       resultValid,
  output logic [`DATA_WIDTH-1:0]     aluResult,
  output logic [`REG_ADDR_WIDTH-1:0] destReg,
  output logic                       regWrite,
  output logic                       memToReg,
  output logic                       memRead,
  output logic                       memWrite,
  output logic [1:0]                 memWidth,
  output logic [`DATA_WIDTH-1:0]     storeData
);
  import pipelinePkg::*;

  logic                   isShift;
  logic [4:0]             shiftAmount;
  logic [`DATA_WIDTH-1:0] operandA;
  logic [`DATA_WIDTH-1:0] operandB;
  logic [`DATA_WIDTH-1:0] aluNext;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  assign isShift = (aluOpOut == ALU_SLL) || (aluOpOut == ALU_SRL) || (aluOpOut == ALU_SRA);

  // Shifts work on rt, everything else on rs
  assign operandA    = isShift ? regData2Out : regData1Out;
  // Fixed amount from shamt, else low bits of rs
  assign shiftAmount = aluSrc0Out ? shamtOut : regData1Out[4:0];

  always_comb begin
    case (aluSrc1Out)
      `SRC1_IMM:   operandB = imm32Out;
      `SRC1_UPPER: operandB = {imm32Out[15:0], 16'b0};
      default:     operandB = regData2Out;
    endcase
  end

  //////////////////////////////
  // ALU
  //////////////////////////////

  always_comb begin
    case (aluOpOut)
      ALU_SUB:  aluNext = operandA - operandB;
      ALU_AND:  aluNext = operandA & operandB;
      ALU_OR:   aluNext = operandA | operandB;
      ALU_XOR:  aluNext = operandA ^ operandB;
      ALU_NOR:  aluNext = ~(operandA | operandB);
      ALU_SLT:  aluNext = {31'b0, $signed(operandA) < $signed(operandB)};
      ALU_SLTU: aluNext = {31'b0, operandA < operandB};
      ALU_SLL:  aluNext = operandA << shiftAmount;
      ALU_SRL:  aluNext = operandA >> shiftAmount;
      ALU_SRA:  aluNext = $unsigned($signed(operandA) >>> shiftAmount);
      ALU_PASS: aluNext = operandB;
      // Add, also the address for loads and stores
      default:  aluNext = operandA + operandB;
    endcase
  end

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////

  // Control bits
  always_ff @(posedge Clock) begin
    if (rst) begin
      resultValid <= 1'b0;
      regWrite    <= 1'b0;
      memToReg    <= 1'b0;
      memRead     <= 1'b0;
      memWrite    <= 1'b0;
    end else begin
      resultValid <= validOut;
      regWrite    <= regWriteOut;
      memToReg    <= memToRegOut;
      memRead     <= memReadOut;
      memWrite    <= memWriteOut;
    end
  end

  // Payload
  always_ff @(posedge Clock) begin
    aluResult <= aluNext;
    destReg   <= regDstOut ? rdOut : rtOut;
    memWidth  <= memWidthOut;
    storeData <= regData2Out;
  end

  // Decoder never asks for a load and a store at once
  assert property (@(posedge Clock) disable iff (rst) !(memRead && memWrite))
    else $error("Load and store requested together");

endmodule

//--- verilog/decodeExecuteTop.sv
`include "pipeline_defines.svh"

module decodeExecuteTop (
  input  logic                       Clock,
  input  logic                       rst,
  input  pipelinePkg::instrWord      instr,
  input  logic                       instrValid,
  input  logic                       stall,
  output logic                       resultValid,
  output logic [`DATA_WIDTH-1:0]     aluResult,
  output logic [`REG_ADDR_WIDTH-1:0] destReg,
  output logic                       regWrite,
  output logic                       memToReg,
  output logic                       memRead,
  output logic                       memWrite,
  output logic [1:0]                 memWidth,
  output logic [`DATA_WIDTH-1:0]     storeData
);
  import pipelinePkg::*;

  // Decode stage
  logic [`REG_ADDR_WIDTH-1:0] idRs, idRt, idRd;
  logic [4:0]                 idShamt;
  aluOpType                   idAluOp;
  logic                       idRegDst, idAluSrc0;
  logic [1:0]                 idAluSrc1, idMemWidth;
  logic [`DATA_WIDTH-1:0]     idImm32, idRegData1, idRegData2;
  logic                       idRegWrite, idMemToReg, idMemRead, idMemWrite, idValid;

  // Execute stage
  logic [`REG_ADDR_WIDTH-1:0] exRt, exRd;
  logic [4:0]                 exShamt;
  aluOpType                   exAluOp;
  logic                       exRegDst, exAluSrc0;
  logic [1:0]                 exAluSrc1, exMemWidth;
  logic [`DATA_WIDTH-1:0]     exImm32, exRegData1, exRegData2;
  logic                       exRegWrite, exMemToReg, exMemRead, exMemWrite, exValid;

  // Write-back straight from EX/MEM, loads excluded
  logic wbEnable;
  assign wbEnable = regWrite && !memToReg;

  instructionDecoder decoder (
    .instr(instr), .instrValid(instrValid),
    .rs(idRs), .rt(idRt), .rd(idRd), .shamt(idShamt),
    .aluOp(idAluOp), .regDst(idRegDst), .aluSrc0(idAluSrc0), .aluSrc1(idAluSrc1),
    .imm32(idImm32), .regWrite(idRegWrite), .memToReg(idMemToReg),
    .memRead(idMemRead), .memWrite(idMemWrite), .memWidth(idMemWidth), .valid(idValid)
  );

  registerFile regs (
    .Clock(Clock), .rst(rst),
    .readAddr1(idRs), .readAddr2(idRt),
    .writeEnable(wbEnable), .writeAddr(destReg), .writeData(aluResult),
    .readData1(idRegData1), .readData2(idRegData2)
  );

  decodeToExecute idEx (
    .Clock(Clock), .rst(rst), .stall(stall),
    .validIn(idValid), .regWriteIn(idRegWrite), .memToRegIn(idMemToReg),
    .memReadIn(idMemRead), .memWriteIn(idMemWrite), .memWidthIn(idMemWidth),
    .aluOpIn(idAluOp), .regDstIn(idRegDst), .aluSrc0In(idAluSrc0), .aluSrc1In(idAluSrc1),
    .shamtIn(idShamt), .regData1In(idRegData1), .regData2In(idRegData2),
    .imm32In(idImm32), .rtIn(idRt), .rdIn(idRd),
    .validOut(exValid), .regWriteOut(exRegWrite), .memToRegOut(exMemToReg),
    .memReadOut(exMemRead), .memWriteOut(exMemWrite), .memWidthOut(exMemWidth),
    .aluOpOut(exAluOp), .regDstOut(exRegDst), .aluSrc0Out(exAluSrc0),
    .aluSrc1Out(exAluSrc1), .shamtOut(exShamt), .regData1Out(exRegData1),
    .regData2Out(exRegData2), .imm32Out(exImm32), .rtOut(exRt), .rdOut(exRd)
  );

  executeUnit execute (
    .Clock(Clock), .rst(rst),
    .validOut(exValid), .regWriteOut(exRegWrite), .memToRegOut(exMemToReg),
    .memReadOut(exMemRead), .memWriteOut(exMemWrite), .memWidthOut(exMemWidth),
    .aluOpOut(exAluOp), .regDstOut(exRegDst), .aluSrc0Out(exAluSrc0),
    .aluSrc1Out(exAluSrc1), .shamtOut(exShamt), .regData1Out(exRegData1),
    .regData2Out(exRegData2), .imm32Out(exImm32), .rtOut(exRt), .rdOut(exRd),
    .resultValid(resultValid), .aluResult(aluResult), .destReg(destReg),
    .regWrite(regWrite), .memToReg(memToReg), .memRead(memRead),
    .memWrite(memWrite), .memWidth(memWidth), .storeData(storeData)
  );

endmodule

//--- tests/decodeExecuteTb.sv
`include "pipeline_defines.svh"

module decodeExecuteTb;
  timeunit 1ns;
  timeprecision 100ps;
  import pipelinePkg::*;

  localparam int RAND_OPS  = 24;
  localparam int RAND_SEED = 64636;

  // Expected flag groups {regWrite, memRead, memWrite}
  localparam logic [2:0] WR = 3'b100;
  localparam logic [2:0] LD = 3'b010;
  localparam logic [2:0] ST = 3'b001;

  typedef struct packed {
    logic [31:0] result;
    logic [4:0]  dest;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic [1:0]  width;
    logic [31:0] store;
  } expectType;

  logic                       Clock = 1'b0;
  logic                       rst;
  instrWord                   instr;
  logic                       instrValid;
  logic                       stall;
  logic                       resultValid;
  logic [`DATA_WIDTH-1:0]     aluResult;
  logic [`REG_ADDR_WIDTH-1:0] destReg;
  logic                       regWrite, memToReg, memRead, memWrite;
  logic [1:0]                 memWidth;
  logic [`DATA_WIDTH-1:0]     storeData;

  // Directed table
  string     nameQ[$];
  instrWord  wordQ[$];
  int        stallQ[$];
  expectType expectQ[$];

  // Random section slots and register model
  instrWord    slotWord[$];
  expectType   slotExpect[$];
  logic [31:0] modelRegs [32];
  logic [31:0] rngState;
  functType    opFunct;
  int          srcA, srcB, dst;
  logic [4:0]  shiftBy;
  functType    functList [13] = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR,
                                  F_NOR, F_SLT, F_SLTU, F_SLL, F_SRL, F_SRA};

  bit testOk;
  int testCount  = 0;
  int failCount  = 0;
  int errorCount = 0;
  int maxStall   = 0;
  int cycleLimit = 0;
  int cycleCount;

  always #50 Clock = ~Clock;

  decodeExecuteTop uut (
    .Clock(Clock), .rst(rst), .instr(instr), .instrValid(instrValid), .stall(stall),
    .resultValid(resultValid), .aluResult(aluResult), .destReg(destReg),
    .regWrite(regWrite), .memToReg(memToReg), .memRead(memRead), .memWrite(memWrite),
    .memWidth(memWidth), .storeData(storeData)
  );

  //////////////////////////////
  // Encoders and models
  //////////////////////////////

  function automatic instrWord rTypeWord(functType funct, int rs, int rt, int rd, int shamt);
    instrWord w;
    w.rFmt.opcode = SPECIAL;
    w.rFmt.rs     = rs[4:0];
    w.rFmt.rt     = rt[4:0];
    w.rFmt.rd     = rd[4:0];
    w.rFmt.shamt  = shamt[4:0];
    w.rFmt.funct  = funct;
    return w;
  endfunction

  function automatic instrWord iTypeWord(opcodeType op, int rs, int rt, logic [15:0] imm);
    instrWord w;
    w.iFmt.opcode = op;
    w.iFmt.rs     = rs[4:0];
    w.iFmt.rt     = rt[4:0];
    w.iFmt.imm    = imm;
    return w;
  endfunction

  function automatic expectType makeExpect(logic [31:0] result, int dest, logic [2:0] flags,
                                           logic [1:0] width, logic [31:0] store);
    expectType e;
    e.result   = result;
    e.dest     = dest[4:0];
    e.regWrite = flags[2];
    e.memRead  = flags[1];
    e.memWrite = flags[0];
    e.width    = width;
    e.store    = store;
    return e;
  endfunction

  // ISA result of an R-type op, a is rs and b is rt
  function automatic logic [31:0] modelR(functType funct, logic [31:0] a, logic [31:0] b,
                                         logic [4:0] shamt);
    case (funct)
      F_ADD, F_ADDU: return a + b;
      F_SUB, F_SUBU: return a - b;
      F_AND:  return a & b;
      F_OR:   return a | b;
      F_XOR:  return a ^ b;
      F_NOR:  return ~(a | b);
      F_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F_SLTU: return (a < b) ? 32'd1 : 32'd0;
      F_SLL:  return b << shamt;
      F_SRL:  return b >> shamt;
      default: return $unsigned($signed(b) >>> shamt);
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic addEntry(input string name, input instrWord word, input int stallCycles,
                          input logic [31:0] result, input int dest, input logic [2:0] flags,
                          input logic [1:0] width, input logic [31:0] store);
    nameQ.push_back(name);
    wordQ.push_back(word);
    stallQ.push_back(stallCycles);
    expectQ.push_back(makeExpect(result, dest, flags, width, store));
  endtask

  // Sample point, just after the edge settles
  task automatic sampleAfterEdge();
    @(posedge Clock);
    #1;
  endtask

  // Called right after a sample, so inputs change 5 ns past the edge
  task automatic driveSlot(input instrWord word, input logic valid, input logic hold);
    #4;
    instr      = word;
    instrValid = valid;
    stall      = hold;
  endtask

  task automatic reportFault(input string testName, input string what);
    $display("%s: %s", testName, what);
    errorCount++;
    testOk = 1'b0;
  endtask

  task automatic checkValue(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("mismatch %s %s expected %h actual %h", testName, field, expected, actual);
        errorCount++;
        testOk = 1'b0;
      end
  endtask

  task automatic expectIdle(input string testName);
    assert (resultValid === 1'b0)
      else reportFault(testName, "result valid in a slot that should be empty");
  endtask

  task automatic checkResult(input string testName, input expectType exp);
    assert (resultValid === 1'b1)
      else reportFault(testName, "no result two edges after issue");
    checkValue(testName, "aluResult", exp.result, aluResult);
    checkValue(testName, "destReg", 32'(exp.dest), 32'(destReg));
    checkValue(testName, "regWrite", 32'(exp.regWrite), 32'(regWrite));
    // Only loads take their register value from memory
    checkValue(testName, "memToReg", 32'(exp.memRead), 32'(memToReg));
    checkValue(testName, "memRead", 32'(exp.memRead), 32'(memRead));
    checkValue(testName, "memWrite", 32'(exp.memWrite), 32'(memWrite));
    checkValue(testName, "memWidth", 32'(exp.width), 32'(memWidth));
    // Store data only means something on a store
    if (exp.memWrite) begin
      checkValue(testName, "storeData", exp.store, storeData);
    end
  endtask

  task automatic finishTest(input string testName);
    testCount++;
    if (!testOk) begin
      failCount++;
    end
    $display("%-18s %s", testName, testOk ? "ok" : "FAILED");
  endtask

  task automatic loadTable();
    // Right after reset, sw exposes rs through the address and rt through store data
    for (int k = 0; k < 32; k += 2) begin
      addEntry($sformatf("zero r%0d r%0d", k, k + 1), iTypeWord(SW, k, k + 1, 16'h0), 0,
               32'h0, k + 1, ST, 2'd2, 32'h0);
    end
    addEntry("ori r1", iTypeWord(ORI, 0, 1, 16'h1234), 0, 32'h00001234, 1, WR, 2'd0, 32'h0);
    addEntry("lui r2", iTypeWord(LUI, 0, 2, 16'h8000), 0, 32'h80000000, 2, WR, 2'd0, 32'h0);
    addEntry("ori r2 low", iTypeWord(ORI, 2, 2, 16'h0001), 1, 32'h80000001, 2, WR, 2'd0, 32'h0);
    addEntry("addi sign", iTypeWord(ADDI, 0, 3, 16'hFFFF), 0, 32'hFFFFFFFF, 3, WR, 2'd0, 32'h0);
    addEntry("addiu r4", iTypeWord(ADDIU, 0, 4, 16'h7FFF), 2, 32'h00007FFF, 4, WR, 2'd0, 32'h0);
    addEntry("add", rTypeWord(F_ADD, 1, 4, 5, 0), 0, 32'h00009233, 5, WR, 2'd0, 32'h0);
    addEntry("add wrap", rTypeWord(F_ADD, 2, 2, 6, 0), 0, 32'h00000002, 6, WR, 2'd0, 32'h0);
    addEntry("sub", rTypeWord(F_SUB, 1, 4, 7, 0), 1, 32'hFFFF9235, 7, WR, 2'd0, 32'h0);
    addEntry("subu", rTypeWord(F_SUBU, 4, 1, 7, 0), 0, 32'h00006DCB, 7, WR, 2'd0, 32'h0);
    addEntry("and", rTypeWord(F_AND, 2, 3, 8, 0), 0, 32'h80000001, 8, WR, 2'd0, 32'h0);
    addEntry("or", rTypeWord(F_OR, 1, 2, 8, 0), 0, 32'h80001235, 8, WR, 2'd0, 32'h0);
    addEntry("xor", rTypeWord(F_XOR, 1, 4, 9, 0), 0, 32'h00006DCB, 9, WR, 2'd0, 32'h0);
    addEntry("nor", rTypeWord(F_NOR, 1, 0, 9, 0), 0, 32'hFFFFEDCB, 9, WR, 2'd0, 32'h0);
    addEntry("slt", rTypeWord(F_SLT, 2, 1, 10, 0), 0, 32'h1, 10, WR, 2'd0, 32'h0);
    addEntry("sltu", rTypeWord(F_SLTU, 2, 1, 10, 0), 3, 32'h0, 10, WR, 2'd0, 32'h0);
    addEntry("sll", rTypeWord(F_SLL, 0, 1, 11, 4), 0, 32'h00012340, 11, WR, 2'd0, 32'h0);
    addEntry("srl", rTypeWord(F_SRL, 0, 2, 11, 4), 0, 32'h08000000, 11, WR, 2'd0, 32'h0);
    addEntry("sra", rTypeWord(F_SRA, 0, 2, 12, 4), 0, 32'hF8000000, 12, WR, 2'd0, 32'h0);
    addEntry("slti sign", iTypeWord(SLTI, 3, 13, 16'h0001), 0, 32'h1, 13, WR, 2'd0, 32'h0);
    addEntry("sltiu", iTypeWord(SLTIU, 1, 13, 16'hFFFF), 0, 32'h1, 13, WR, 2'd0, 32'h0);
    addEntry("andi zero", iTypeWord(ANDI, 3, 14, 16'h8001), 0, 32'h00008001, 14, WR, 2'd0, 32'h0);
    addEntry("xori zero", iTypeWord(XORI, 3, 14, 16'hFFFF), 0, 32'hFFFF0000, 14, WR, 2'd0, 32'h0);
    // Loads give the address only
    addEntry("lw", iTypeWord(LW, 1, 15, 16'h0010), 0, 32'h00001244, 15, LD, 2'd2, 32'h0);
    addEntry("lh", iTypeWord(LH, 1, 15, 16'hFFFC), 0, 32'h00001230, 15, LD, 2'd1, 32'h0);
    addEntry("lb", iTypeWord(LB, 0, 16, 16'h0001), 0, 32'h00000001, 16, LD, 2'd0, 32'h0);
    addEntry("load target", rTypeWord(F_OR, 15, 16, 17, 0), 0, 32'h0, 17, WR, 2'd0, 32'h0);
    addEntry("sw", iTypeWord(SW, 4, 1, 16'h0008), 0, 32'h00008007, 1, ST, 2'd2, 32'h00001234);
    addEntry("sh", iTypeWord(SH, 1, 2, 16'h0000), 0, 32'h00001234, 2, ST, 2'd1, 32'h80000001);
    addEntry("sb", iTypeWord(SB, 1, 3, 16'hFFFF), 2, 32'h00001233, 3, ST, 2'd0, 32'hFFFFFFFF);
    // Write to r0 still shows on the outputs, the register stays zero
    addEntry("write r0", iTypeWord(ADDI, 1, 0, 16'h0005), 0, 32'h00001239, 0, WR, 2'd0, 32'h0);
    addEntry("r0 unchanged", rTypeWord(F_OR, 0, 0, 18, 0), 0, 32'h0, 18, WR, 2'd0, 32'h0);
  endtask

  //////////////////////////////
  // Run limit
  //////////////////////////////

  initial begin
    wait (cycleLimit != 0);
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge Clock);
      cycleCount++;
    end
    $display("Run stopped by timeout after %0d cycles", cycleCount);
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    instr      = '0;
    instrValid = 1'b0;
    stall      = 1'b0;
    rst        = 1'b1;
    loadTable();
    foreach (stallQ[i]) begin
      if (stallQ[i] > maxStall) begin
        maxStall = stallQ[i];
      end
    end
    // Random slots counted like table entries
    cycleLimit = (nameQ.size() + RAND_OPS + 9) * (maxStall + 4) + 200;

    repeat (8) @(posedge Clock);
    #5 rst = 1'b0;

    sampleAfterEdge();
    testOk = 1'b1;
    assert ({resultValid, regWrite, memRead, memWrite} === 4'b0)
      else reportFault("reset controls", "control outputs not low after reset");
    finishTest("reset controls");

    // One instruction at a time, stalled first when the entry asks for it
    for (int i = 0; i < nameQ.size(); i++) begin
      testOk = 1'b1;
      driveSlot(wordQ[i], 1'b1, stallQ[i] > 0);
      for (int s = 0; s < stallQ[i]; s++) begin
        sampleAfterEdge();
        expectIdle(nameQ[i]);
        driveSlot(wordQ[i], 1'b1, s < stallQ[i] - 1);
      end
      // Accept edge
      sampleAfterEdge();
      expectIdle(nameQ[i]);
      driveSlot('0, 1'b0, 1'b0);
      sampleAfterEdge();
      checkResult(nameQ[i], expectQ[i]);
      finishTest(nameQ[i]);
    end

    // Random operands into r20..r23, each ori four slots behind its lui
    testOk   = 1'b1;
    rngState = RAND_SEED;
    for (int r = 20; r < 24; r++) begin
      rngState     = xorshift32(rngState);
      modelRegs[r] = rngState;
      slotWord.push_back(iTypeWord(LUI, 0, r, rngState[31:16]));
      slotExpect.push_back(makeExpect({rngState[31:16], 16'h0}, r, WR, 2'd0, 32'h0));
    end
    for (int r = 20; r < 24; r++) begin
      slotWord.push_back(iTypeWord(ORI, r, r, modelRegs[r][15:0]));
      slotExpect.push_back(makeExpect(modelRegs[r], r, WR, 2'd0, 32'h0));
    end
    // Spacer, keeps the first op two slots behind the last ori
    slotWord.push_back(rTypeWord(F_OR, 0, 0, 24, 0));
    slotExpect.push_back(makeExpect(32'h0, 24, WR, 2'd0, 32'h0));
    // Results land in r24..r31, never read back
    for (int n = 0; n < RAND_OPS; n++) begin
      rngState = xorshift32(rngState);
      opFunct  = functList[rngState % 13];
      srcA     = 20 + int'(rngState[9:8]);
      srcB     = 20 + int'(rngState[11:10]);
      dst      = 24 + int'(rngState[14:12]);
      shiftBy  = rngState[20:16];
      slotWord.push_back(rTypeWord(opFunct, srcA, srcB, dst, int'(shiftBy)));
      slotExpect.push_back(makeExpect(modelR(opFunct, modelRegs[srcA], modelRegs[srcB],
                                             shiftBy), dst, WR, 2'd0, 32'h0));
    end

    // Back to back, slot j-1 shows after the edge that accepts slot j
    for (int j = 0; j <= slotWord.size(); j++) begin
      if (j < slotWord.size()) begin
        driveSlot(slotWord[j], 1'b1, 1'b0);
      end else begin
        driveSlot('0, 1'b0, 1'b0);
      end
      sampleAfterEdge();
      if (j > 0) begin
        checkResult($sformatf("random slot %0d", j - 1), slotExpect[j - 1]);
      end
    end
    driveSlot('0, 1'b0, 1'b0);
    sampleAfterEdge();
    expectIdle("random drain");
    finishTest("random section");

    $display("Tests %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/pipelinePkg.sv
verilog/instructionDecoder.sv
verilog/registerFile.sv
verilog/decodeToExecute.sv
verilog/executeUnit.sv
verilog/decodeExecuteTop.sv
tests/decodeExecuteTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module decodeExecuteTb \
  -f project.f -o decodeExecuteSim \
  && ./obj_dir/decodeExecuteSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation clean"
